// File: tb.f
+incdir+logic
logic/opcodes.sv
logic/control.sv
logic/aluUnit.sv
logic/dataPath.sv
logic/cpuCore.sv
testbench/clockGen.sv
testbench/tbCpuCore.sv

// File: Makefile
LOG = sim.log

sim:
	verilator --binary --timing -f tb.f --top-module tbCpuCore -o simv
	./obj_dir/simv > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

// File: testbench/tbCpuCore.sv
`timescale 1ns/100ps

`include "core_defs.svh"

module tbCpuCore;

   localparam int randomCount = 24;
   localparam int clockPeriod = 40;

   logic                    Clock;
   logic                    nReset;
   logic [`DATA_WIDTH-1:0]  busIn = '0;
   logic [`DATA_WIDTH-1:0]  busOut;
   logic                    addrLatch;
   logic                    nMemEnable;
   logic                    nReadEnable;
   logic                    nWriteEnable;

   // Program table and what the reference model expects from it
   logic [15:0] progTable [256];
   int          progLength;
   int          expLatchCycle [$];
   logic [15:0] expLatchAddr [$];
   int          expStoreCycle [$];
   logic [15:0] expStoreAddr [$];
   logic [15:0] expStoreData [$];
   int          totalCycles;
   bit          built = 1'b0;

   logic [15:0] refRegs [8];
   logic        refCarry;
   logic [15:0] lfsr = 16'd15;

   logic [15:0] mem [256];
   logic [7:0]  memAddr;

   int          cycle = 0;
   int          latchIdx = 0;
   int          storeIdx = 0;
   int          writeRun = 0;
   logic [15:0] lastLatchAddr;
   bit          done = 1'b0;
   int          resetErrors = 0;
   int          fetchErrors = 0;
   int          storeErrors = 0;

   clockGen u_clockGen (
      .Clock  (Clock),
      .nReset (nReset)
   );

   cpuCore u_cpuCore (
      .Clock        (Clock),
      .nReset       (nReset),
      .busIn        (busIn),
      .busOut       (busOut),
      .addrLatch    (addrLatch),
      .nMemEnable   (nMemEnable),
      .nReadEnable  (nReadEnable),
      .nWriteEnable (nWriteEnable)
   );

   // Fibonacci LFSR, taps 16 14 13 11, one step per bit taken
   function automatic logic [15:0] takeBits(input int count);
      logic        fb;
      logic [15:0] value;
      value = '0;
      for (int i = 0; i < count; i++) begin
         fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
         lfsr = {lfsr[14:0], fb};
         value = {value[14:0], fb};
      end
      return value;
   endfunction

   function automatic logic [15:0] encode(logic [4:0] op, int rd, int rs1, logic [4:0] low);
      return {op, 3'(rd), 3'(rs1), low};
   endfunction

   // Reference model of one instruction, also records expected bus events
   task automatic addInstr(input logic [15:0] instr);
      logic [4:0]  op;
      logic [2:0]  rd;
      logic [2:0]  rs1;
      logic [2:0]  rs2;
      logic [16:0] sum;
      bit          arith;
      op  = instr[15:11];
      rd  = instr[10:8];
      rs1 = instr[7:5];
      rs2 = instr[4:2];
      progTable[progLength] = instr;
      expLatchCycle.push_back(totalCycles);
      expLatchAddr.push_back(16'(progLength));
      progLength++;
      sum   = '0;
      arith = 1'b1;
      case (op)
         opcodes::ADD:   sum = 17'(refRegs[rs1]) + 17'(refRegs[rs2]);
         opcodes::ADDI:  sum = 17'(refRegs[rs1]) + 17'(instr[4:0]);
         opcodes::ADDIB: sum = 17'(refRegs[rd]) + 17'(instr[7:0]);
         opcodes::ADC:   sum = 17'(refRegs[rs1]) + 17'(refRegs[rs2]) + 17'(refCarry);
         opcodes::ADCI:  sum = 17'(refRegs[rs1]) + 17'(instr[4:0]) + 17'(refCarry);
         default: arith = 1'b0;
      endcase
      if (op == opcodes::STW) begin
         expLatchCycle.push_back(totalCycles + 4);
         expLatchAddr.push_back(refRegs[rs1]);
         expStoreCycle.push_back(totalCycles + 6);   // Exe3
         expStoreAddr.push_back(refRegs[rs1]);
         expStoreData.push_back(refRegs[rd]);
         totalCycles += 8;
      end else begin
         if (arith) begin
            refRegs[rd] = sum[15:0];
            refCarry = sum[16];
         end
         totalCycles += 5;
      end
   endtask

   task automatic buildTable();
      logic [15:0] sel;
      logic [15:0] rd;
      logic [15:0] field;
      logic [4:0]  op;
      for (int i = 0; i < 256; i++)
         progTable[i] = {5'b11111, 11'(i)};   // Unused words decode as no-ops
      for (int i = 0; i < 8; i++)
         refRegs[i] = '0;
      refCarry = 1'b0;
      progLength = 0;
      totalCycles = 2;   // Idle cycle, then the first fetch
      addInstr({opcodes::ADDIB, 3'd7, 8'hC0});   // Store base kept away from code
      addInstr(encode(opcodes::ADDI, 1, 0, 5'd5));
      addInstr(encode(opcodes::ADD, 2, 1, {3'd1, 2'b00}));
      addInstr(encode(opcodes::STW, 2, 7, 5'd0));
      // Build 0xFFFF by doubling
      addInstr({opcodes::ADDIB, 3'd4, 8'hFF});
      for (int i = 0; i < 8; i++)
         addInstr(encode(opcodes::ADD, 4, 4, {3'd4, 2'b00}));
      addInstr({opcodes::ADDIB, 3'd4, 8'hFF});
      addInstr(encode(opcodes::ADDI, 5, 4, 5'd1));           // Wraps, sets carry
      addInstr(encode(opcodes::ADC, 6, 1, {3'd0, 2'b00}));
      addInstr(encode(opcodes::STW, 6, 7, 5'd0));
      addInstr(encode(opcodes::ADDI, 5, 4, 5'd1));
      addInstr(encode(opcodes::ADCI, 6, 0, 5'd3));
      addInstr(encode(opcodes::STW, 6, 7, 5'd0));
      addInstr(encode(opcodes::ADD, 6, 1, {3'd1, 2'b00}));  // No wrap, clears carry
      addInstr(encode(opcodes::ADC, 6, 0, {3'd0, 2'b00}));
      addInstr(encode(opcodes::STW, 6, 7, 5'd0));
      for (int i = 0; i < randomCount; i++) begin
         sel = takeBits(3);
         rd = takeBits(3);
         if (rd == 7)
            rd = 6;                  // r7 holds the store base
         field = takeBits(8);
         case (sel % 6)
            0: op = opcodes::ADD;
            1: op = opcodes::ADDI;
            2: op = opcodes::ADDIB;
            3: op = opcodes::ADC;
            4: op = opcodes::ADCI;
            default: op = opcodes::STW;
         endcase
         if (op == opcodes::STW)
            field[7:5] = 3'd7;
         addInstr({op, rd[2:0], field[7:0]});
      end
      // Fetch of the trailing no-op marks the end
      expLatchCycle.push_back(totalCycles);
      expLatchAddr.push_back(16'(progLength));
   endtask

   // Memory model, loaded from the table during reset
   always @(posedge Clock) begin
      if (!nReset) begin
         for (int i = 0; i < 256; i++)
            mem[i] <= progTable[i];
         busIn <= '0;
         memAddr <= '0;
      end else begin
         if (addrLatch)
            memAddr <= busOut[7:0];
         if (!nMemEnable && !nReadEnable)
            busIn <= mem[memAddr];
         if (!nMemEnable && !nWriteEnable)
            mem[memAddr] <= busOut;
      end
   end

   always @(posedge Clock) begin
      if (!nReset || cycle == 0) begin
         if (built && (addrLatch !== 1'b0 || nMemEnable !== 1'b1 || nReadEnable !== 1'b1
               || nWriteEnable !== 1'b1)) begin
            $write("** Error at %0t ns: addrLatch nMemEnable nReadEnable nWriteEnable",
                   $time);
            $display(" expected 0 1 1 1, got %b %b %b %b", addrLatch, nMemEnable,
                     nReadEnable, nWriteEnable);
            resetErrors++;
         end
         if (nReset) begin
            cycle = 1;   // First cycle after release
            $display("reset bus idle: %s", (resetErrors == 0) ? "ok" : "failed");
         end
      end else if (!done) begin
         cycle++;
         if (addrLatch) begin
            lastLatchAddr = busOut;
            if (cycle != expLatchCycle[latchIdx]) begin
               $display("** Error at %0t ns: addrLatch cycle expected %0d, got %0d",
                        $time, expLatchCycle[latchIdx], cycle);
               fetchErrors++;
            end
            if (busOut !== expLatchAddr[latchIdx]) begin
               $display("** Error at %0t ns: busOut expected 0x%h, got 0x%h",
                        $time, expLatchAddr[latchIdx], busOut);
               fetchErrors++;
            end
            latchIdx++;
            if (latchIdx == expLatchCycle.size())
               done = 1'b1;
         end
         if (!nMemEnable && !nWriteEnable) begin
            writeRun++;
            if (writeRun == 2) begin
               if (storeIdx >= expStoreData.size()) begin
                  $display("Store outside any STW at %0t ns", $time);
                  storeErrors++;
               end else begin
                  if (cycle != expStoreCycle[storeIdx]) begin
                     $display("** Error at %0t ns: store cycle expected %0d, got %0d",
                              $time, expStoreCycle[storeIdx], cycle);
                     storeErrors++;
                  end
                  if (lastLatchAddr !== expStoreAddr[storeIdx]) begin
                     $display("** Error at %0t ns: store address expected 0x%h, got 0x%h",
                              $time, expStoreAddr[storeIdx], lastLatchAddr);
                     storeErrors++;
                  end
                  if (busOut !== expStoreData[storeIdx]) begin
                     $display("** Error at %0t ns: busOut expected 0x%h, got 0x%h",
                              $time, expStoreData[storeIdx], busOut);
                     storeErrors++;
                  end
               end
               storeIdx++;
            end else if (writeRun > 2) begin
               $display("Write enable held longer than two cycles at %0t ns", $time);
               storeErrors++;
            end
         end else begin
            if (writeRun == 1) begin
               $display("Write enable pulse of one cycle at %0t ns", $time);
               storeErrors++;
            end
            writeRun = 0;
         end
      end
   end

   initial begin
      buildTable();
      built = 1'b1;
      wait (done);
      if (storeIdx != expStoreData.size()) begin
         $display("Saw %0d stores, reference has %0d", storeIdx, expStoreData.size());
         storeErrors++;
      end
      $display("fetch and latch timing: %s", (fetchErrors == 0) ? "ok" : "failed");
      $display("store sequence: %s", (storeErrors == 0) ? "ok" : "failed");
      $display("instructions %0d, latches %0d, stores %0d, errors %0d", progLength,
               latchIdx, storeIdx, resetErrors + fetchErrors + storeErrors);
      if (resetErrors + fetchErrors + storeErrors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

   // Watchdog
   initial begin
      wait (built);
      #((totalCycles + 8 + 50) * clockPeriod);
      $display("Timeout after %0t ns, %0d of %0d latches seen", $time, latchIdx,
               expLatchCycle.size());
      $display("=== FAIL ===");
      $finish;
   end

endmodule

// File: testbench/clockGen.sv
`timescale 1ns/100ps

module clockGen (
   output logic Clock,
   output logic nReset
);

   localparam int halfPeriod = 20;   // 40 ns period
   localparam int resetCycles = 8;

   initial begin
      Clock = 1'b0;
      forever #halfPeriod Clock = ~Clock;
   end

   initial begin
      nReset = 1'b0;
      repeat (resetCycles) @(posedge Clock);
      nReset <= 1'b1;
   end

endmodule

// File: logic/cpuCore.sv
`timescale 1ns/100ps

`include "core_defs.svh"

module cpuCore (
   input  logic                    Clock,
   input  logic                    nReset,
   input  logic [`DATA_WIDTH-1:0]  busIn,
   output logic [`DATA_WIDTH-1:0]  busOut,
   output logic                    addrLatch,
   output logic                    nMemEnable,
   output logic                    nReadEnable,
   output logic                    nWriteEnable
);

   opcodes::opcode_t        opcode;
   opcodes::aluFunc_t       aluOp;
   logic                    aluEn;
   logic                    regWe;
   logic                    pcWe;
   logic                    irWe;
   logic                    rs1Sel;
   logic                    op2Sel;
   logic                    immWide;
   logic                    busDrivePc;
   logic                    busDriveData;
   logic [`DATA_WIDTH-1:0]  opA;
   logic [`DATA_WIDTH-1:0]  opB;
   logic [`DATA_WIDTH-1:0]  result;

   control u_control (
      .Clock        (Clock),
      .nReset       (nReset),
      .opcode       (opcode),
      .aluOp        (aluOp),
      .aluEn        (aluEn),
      .regWe        (regWe),
      .pcWe         (pcWe),
      .irWe         (irWe),
      .rs1Sel       (rs1Sel),
      .op2Sel       (op2Sel),
      .immWide      (immWide),
      .busDrivePc   (busDrivePc),
      .busDriveData (busDriveData),
      .addrLatch    (addrLatch),
      .nMemEnable   (nMemEnable),
      .nReadEnable  (nReadEnable),
      .nWriteEnable (nWriteEnable)
   );

   aluUnit u_aluUnit (
      .Clock  (Clock),
      .nReset (nReset),
      .aluOp  (aluOp),
      .aluEn  (aluEn),
      .opA    (opA),
      .opB    (opB),
      .result (result)
   );

   dataPath u_dataPath (
      .Clock        (Clock),
      .nReset       (nReset),
      .irWe         (irWe),
      .regWe        (regWe),
      .pcWe         (pcWe),
      .rs1Sel       (rs1Sel),
      .op2Sel       (op2Sel),
      .immWide      (immWide),
      .busDrivePc   (busDrivePc),
      .busDriveData (busDriveData),
      .busIn        (busIn),
      .result       (result),
      .busOut       (busOut),
      .opA          (opA),
      .opB          (opB),
      .opcode       (opcode)
   );

endmodule

// File: logic/dataPath.sv
`timescale 1ns/100ps

`include "core_defs.svh"

module dataPath (
   input  logic                    Clock,
   input  logic                    nReset,
   input  logic                    irWe,
   input  logic                    regWe,
   input  logic                    pcWe,
   input  logic                    rs1Sel,
   input  logic                    op2Sel,
   input  logic                    immWide,
   input  logic                    busDrivePc,
   input  logic                    busDriveData,
   input  logic [`DATA_WIDTH-1:0]  busIn,
   input  logic [`DATA_WIDTH-1:0]  result,
   output logic [`DATA_WIDTH-1:0]  busOut,
   output logic [`DATA_WIDTH-1:0]  opA,
   output logic [`DATA_WIDTH-1:0]  opB,
   output opcodes::opcode_t        opcode
);

   localparam logic [`DATA_WIDTH-1:0] pcStep = 1;

   logic [`DATA_WIDTH-1:0]      regs [`REG_COUNT];
   logic [`DATA_WIDTH-1:0]      pc;
   logic [`DATA_WIDTH-1:0]      ir;
   logic [`REG_INDEX_WIDTH-1:0] rd;
   logic [`REG_INDEX_WIDTH-1:0] rs1;
   logic [`REG_INDEX_WIDTH-1:0] rs2;
   logic [`DATA_WIDTH-1:0]      imm5;
   logic [`DATA_WIDTH-1:0]      imm8;

   // Instruction fields
   assign opcode = opcodes::opcode_t'(ir[15:11]);
   assign rd     = ir[10:8];
   assign rs1    = ir[7:5];
   assign rs2    = ir[4:2];
   assign imm5   = {{(`DATA_WIDTH-5){1'b0}}, ir[4:0]};
   assign imm8   = {{(`DATA_WIDTH-8){1'b0}}, ir[7:0]};

   // Operand selection
   assign opA = rs1Sel ? regs[rd] : regs[rs1];

   always_comb begin
      if (op2Sel)
         opB = regs[rs2];
      else if (immWide)
         opB = imm8;
      else
         opB = imm5;
   end

   always_comb begin
      if (busDrivePc)
         busOut = pc;
      else if (busDriveData)
         busOut = regs[rd];    // Store data
      else
         busOut = regs[rs1];   // Store address
   end

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         for (int i = 0; i < `REG_COUNT; i++)
            regs[i] <= '0;
      end else if (regWe) begin
         regs[rd] <= result;
      end
   end

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset)
         pc <= `RESET_PC;
      else if (pcWe)
         pc <= pc + pcStep;
   end

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset)
         ir <= '0;             // Decodes as a no-op
      else if (irWe)
         ir <= busIn;
   end

endmodule

// File: logic/aluUnit.sv
`timescale 1ns/100ps

`include "core_defs.svh"

module aluUnit (
   input  logic                    Clock,
   input  logic                    nReset,
   input  opcodes::aluFunc_t       aluOp,
   input  logic                    aluEn,
   input  logic [`DATA_WIDTH-1:0]  opA,
   input  logic [`DATA_WIDTH-1:0]  opB,
   output logic [`DATA_WIDTH-1:0]  result
);

   logic                  carry;
   logic                  carryIn;
   logic [`DATA_WIDTH:0]  sum;     // Extra bit is carry out

   // Stored carry only enters for add-with-carry
   assign carryIn = (aluOp == opcodes::FnAdc) ? carry : 1'b0;

   always_comb begin
      sum = {1'b0, opA} + {1'b0, opB} + {{`DATA_WIDTH{1'b0}}, carryIn};
      if (aluOp == opcodes::FnNop)
         result = '0;
      else
         result = sum[`DATA_WIDTH-1:0];
   end

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset)
         carry <= 1'b0;
      else if (aluEn)
         carry <= sum[`DATA_WIDTH];
   end

endmodule

// File: logic/control.sv
`timescale 1ns/100ps

module control (
   input  logic               Clock,
   input  logic               nReset,
   input  opcodes::opcode_t   opcode,
   output opcodes::aluFunc_t  aluOp,
   output logic               aluEn,
   output logic               regWe,
   output logic               pcWe,
   output logic               irWe,
   output logic               rs1Sel,
   output logic               op2Sel,
   output logic               immWide,
   output logic               busDrivePc,
   output logic               busDriveData,
   output logic               addrLatch,
   output logic               nMemEnable,
   output logic               nReadEnable,
   output logic               nWriteEnable
);

   // Idle holds the bus quiet for one cycle after reset
   typedef enum logic [1:0] {
      Idle,
      Fetch,
      Execute
   } majorState_t;

   typedef enum logic [1:0] {
      Fet1,
      Fet2,
      Fet3,
      Fet4
   } fetchState_t;

   typedef enum logic [1:0] {
      Exe1,
      Exe2,
      Exe3,
      Exe4
   } execState_t;

   majorState_t state;
   fetchState_t fetchSub;
   execState_t  execSub;

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         state    <= Idle;
         fetchSub <= Fet1;
         execSub  <= Exe1;
      end else begin
         case (state)
            Idle: begin
               state    <= Fetch;
               fetchSub <= Fet1;
            end
            Fetch: begin
               case (fetchSub)
                  Fet1: fetchSub <= Fet2;
                  Fet2: fetchSub <= Fet3;
                  Fet3: fetchSub <= Fet4;
                  Fet4: begin
                     state    <= Execute;
                     fetchSub <= Fet1;
                     execSub  <= Exe1;
                  end
               endcase
            end
            Execute: begin
               case (execSub)
                  Exe1: begin
                     if (opcode == opcodes::STW)
                        execSub <= Exe2;      // Store needs the bus
                     else
                        state <= Fetch;
                  end
                  Exe2: execSub <= Exe3;
                  Exe3: execSub <= Exe4;
                  Exe4: begin
                     state   <= Fetch;
                     execSub <= Exe1;
                  end
               endcase
            end
            default: state <= Idle;
         endcase
      end
   end

   always_comb begin
      aluOp        = opcodes::FnNop;
      aluEn        = 1'b0;
      regWe        = 1'b0;
      pcWe         = 1'b0;
      irWe         = 1'b0;
      rs1Sel       = 1'b0;
      op2Sel       = 1'b0;
      immWide      = 1'b0;
      busDrivePc   = 1'b0;
      busDriveData = 1'b0;
      addrLatch    = 1'b0;
      nMemEnable   = 1'b1;
      nReadEnable  = 1'b1;
      nWriteEnable = 1'b1;
      case (state)
         Fetch: begin
            case (fetchSub)
               Fet1: begin
                  addrLatch  = 1'b1;
                  busDrivePc = 1'b1;
               end
               Fet2, Fet3: begin
                  nMemEnable  = 1'b0;
                  nReadEnable = 1'b0;
               end
               Fet4: begin
                  nMemEnable  = 1'b0;
                  nReadEnable = 1'b0;
                  irWe        = 1'b1;   // Capture busIn
               end
            endcase
         end
         Execute: begin
            case (execSub)
               Exe1: begin
                  case (opcode)
                     opcodes::ADD: begin
                        aluOp  = opcodes::FnAdd;
                        op2Sel = 1'b1;
                     end
                     opcodes::ADDI: aluOp = opcodes::FnAdd;
                     opcodes::ADDIB: begin
                        aluOp   = opcodes::FnAdd;
                        rs1Sel  = 1'b1;      // rd is also the source
                        immWide = 1'b1;
                     end
                     opcodes::ADC: begin
                        aluOp  = opcodes::FnAdc;
                        op2Sel = 1'b1;
                     end
                     opcodes::ADCI: aluOp = opcodes::FnAdc;
                     opcodes::STW: addrLatch = 1'b1;   // Address from rs1
                     default: ;
                  endcase
                  // Arithmetic writes back and updates carry
                  if (aluOp != opcodes::FnNop) begin
                     regWe = 1'b1;
                     aluEn = 1'b1;
                  end
                  if (opcode != opcodes::STW)
                     pcWe = 1'b1;
               end
               Exe2, Exe3: begin
                  busDriveData = 1'b1;
                  nMemEnable   = 1'b0;
                  nWriteEnable = 1'b0;
               end
               Exe4: pcWe = 1'b1;
            endcase
         end
         default: ;
      endcase
   end

endmodule

// File: logic/opcodes.sv
package opcodes;

   // Instruction opcodes in bits 15 to 11
   // Any code not listed here only advances the PC
   typedef enum logic [4:0] {
      ADD   = 5'b00001, // rd = rs1 + rs2
      ADDI  = 5'b00010, // rd = rs1 + imm5
      ADDIB = 5'b00011, // rd = rd + imm8
      ADC   = 5'b00100, // rd = rs1 + rs2 + carry
      ADCI  = 5'b00101, // rd = rs1 + imm5 + carry
      STW   = 5'b00110  // mem[rs1] = rd
   } opcode_t;

   // Adder functions
   typedef enum logic [1:0] {
      FnNop = 2'b00,
      FnAdd = 2'b01,
      FnAdc = 2'b10    // Adds stored carry
   } aluFunc_t;

endpackage

// File: logic/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Word size of registers, PC and bus
`define DATA_WIDTH 16

// General register file
`define REG_COUNT 8
`define REG_INDEX_WIDTH 3

// First fetch address after reset
`define RESET_PC 0

`endif
